// ==== sources.f ====
source/fma_pkg.sv
source/fma_pipe_reg.sv
source/fma_operand_prep.sv
source/fma_mantissa_add.sv
source/fma_normalize.sv
source/fma_round_select.sv
source/fma_top.sv
testbench/fma_properties.sv
testbench/fma_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the FMA testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module fma_tb -f sources.f -o fma_sim &&
  ./obj_dir/fma_sim > sim.log 2>&1

cat sim.log 2>/dev/null

grep -q "^ALL CHECKS PASSED$" sim.log && echo "Simulation passed" ||
  { echo "Simulation failed"; exit 1; }

// ==== testbench/fma_tb.sv ====
// Binary32 FMA testbench; expects RNE integer cases to stay exact and ends at a cycle limit
`default_nettype none

module fma_tb import fma_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  logic     clk_i;
  logic     arst_n_i;
  logic     in_valid_i;
  fma_req_t in_req_i;
  logic     in_ready_o;
  logic     out_valid_o;
  fma_rsp_t out_rsp_o;
  logic     out_ready_i;

  fma_req_t stim_q[$];
  fma_rsp_t expect_q[$];
  integer   seed;
  int       errors = 0;
  int       received_count = 0;
  int       cycles = 0;
  int       timeout_limit = 0;
  int       directed_count = 0;
  int       accept_edge = 0;
  logic     any_accepted = 1'b0;
  logic     first_out_seen = 1'b0;
  logic     random_ready = 1'b0;

  fma_top UUT (
    .clk_i, .arst_n_i, .in_valid_i, .in_req_i, .in_ready_o,
    .out_valid_o, .out_rsp_o, .out_ready_i
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // -------------------------------------------------------------------------
  // Reference rules
  // -------------------------------------------------------------------------
  // Exact encoding of a small integer
  function automatic fp_word_t int_to_word(input int value);
    int                  mag;
    int                  msb;
    logic [EXP_BITS-1:0] exp_field;
    logic [MAN_BITS-1:0] man_field;
    if (value == 0) return '0;
    mag = (value < 0) ? -value : value;
    msb = 0;
    for (int i = 0; i < PRECISION_BITS; i++) begin
      if (mag[i]) msb = i;
    end
    exp_field = EXP_BITS'(BIAS + msb);
    // Implicit bit drops off the top
    man_field = MAN_BITS'(mag << (MAN_BITS - msb));
    return {value < 0, exp_field, man_field};
  endfunction

  function automatic int small_int();
    int mag;
    mag = 1 + int'($unsigned($random(seed)) % 15);
    if ($random(seed) & 1) return -mag;
    return mag;
  endfunction

  task automatic queue_case(input fp_word_t a, input fp_word_t b, input fp_word_t c,
                            input fma_op_e op, input logic op_mod, input roundmode_e rm,
                            input fp_word_t result, input status_t status);
    fma_req_t req;
    fma_rsp_t rsp;
    req.a        = a;
    req.b        = b;
    req.c        = c;
    req.op       = op;
    req.op_mod   = op_mod;
    req.rnd_mode = rm;
    // Tag counts up so order is visible at the output
    req.tag      = tag_t'(stim_q.size());
    rsp.result   = result;
    rsp.status   = status;
    rsp.tag      = req.tag;
    stim_q.push_back(req);
    expect_q.push_back(rsp);
  endtask

  task automatic integer_case(input fma_op_e op, input logic op_mod);
    int va;
    int vb;
    int vc;
    int prod;
    int addend;
    va     = small_int();
    vb     = small_int();
    vc     = small_int();
    // ADD uses +1.0 as multiplicand
    prod   = (op == ADD) ? vb : va * vb;
    prod   = (op == FNMSUB) ? -prod : prod;
    addend = op_mod ? -vc : vc;
    // MUL adds -0.0
    addend = (op == MUL) ? 0 : addend;
    // Exact cancellation under RNE gives +0
    queue_case(int_to_word(va), int_to_word(vb), int_to_word(vc), op, op_mod, RNE,
               int_to_word(prod + addend), status_t'(4'b0000));
  endtask

  task automatic special_case(input int idx);
    case (idx)
      // inf times zero raises NV
      0: queue_case(32'h7F80_0000, 32'h0000_0000, 32'h3F80_0000, FMADD, 1'b0, RNE,
                    CANONICAL_NAN, status_t'(4'b1000));
      // Signalling NaN multiplicand
      1: queue_case(32'h7F80_0001, 32'h3F80_0000, 32'h0000_0000, FMADD, 1'b0, RNE,
                    CANONICAL_NAN, status_t'(4'b1000));
      // Quiet NaN addend raises nothing
      2: queue_case(32'h3F80_0000, 32'h4000_0000, 32'h7FC0_0000, FMADD, 1'b0, RNE,
                    CANONICAL_NAN, status_t'(4'b0000));
      // +inf minus inf
      3: queue_case(32'h7F80_0000, 32'h3F80_0000, 32'h7F80_0000, FMADD, 1'b1, RNE,
                    CANONICAL_NAN, status_t'(4'b1000));
      default: queue_case(32'h7F80_0000, 32'hC000_0000, 32'h40A0_0000, FMADD, 1'b0, RNE,
                          32'hFF80_0000, status_t'(4'b0000));
    endcase
  endtask

  // (1+2^-23)^2 lies just above 3F800002
  // Remainder is far below half an ulp so only RUP goes up
  task automatic rounding_case(input roundmode_e rm);
    queue_case(32'h3F80_0001, 32'h3F80_0001, 32'h0000_0000, MUL, 1'b0, rm,
               (rm == RUP) ? 32'h3F80_0003 : 32'h3F80_0002,
               status_t'(4'b0001));
  endtask

  // Max finite times two raises OF and NX
  task automatic overflow_case(input roundmode_e rm);
    queue_case(32'h7F7F_FFFF, 32'h4000_0000, 32'h0000_0000, MUL, 1'b0, rm,
               (rm == RNE || rm == RUP) ? 32'h7F80_0000 : 32'h7F7F_FFFF,
               status_t'(4'b0101));
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (expected == actual) else begin
      $display("ERR %s expected %h got %h", name, expected, actual);
      errors++;
    end
  endtask

  task automatic compare_response();
    fma_rsp_t expected;
    assert (expect_q.size() != 0) else begin
      $display("Response arrived with no outstanding request");
      errors++;
    end
    if (expect_q.size() != 0) begin
      expected = expect_q.pop_front();
      check_value("out_rsp_o.tag", {28'b0, expected.tag}, {28'b0, out_rsp_o.tag});
      check_value("out_rsp_o.result", expected.result, out_rsp_o.result);
      check_value("out_rsp_o.status", {28'b0, expected.status}, {28'b0, out_rsp_o.status});
    end
    received_count++;
  endtask

  // -------------------------------------------------------------------------
  // Cycle count and timeout
  // -------------------------------------------------------------------------
  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (timeout_limit > 0 && cycles >= timeout_limit) begin
      $display("Timeout after %0d cycles with %0d of %0d responses", cycles,
               received_count, stim_q.size());
      $display("CHECKS FAILED");
      $finish;
    end
  end

  // Output side sampled 1 ns after the falling edge
  always @(negedge clk_i) begin
    if (arst_n_i) begin
      out_ready_i = random_ready ? 1'($random(seed)) : 1'b1;
      #1;
      assert (any_accepted || !out_valid_o) else begin
        $display("Output valid before any request was accepted");
        errors++;
      end
      if (out_valid_o && !first_out_seen) begin
        first_out_seen = 1'b1;
        // Idle pipe gives two cycles of latency
        assert (cycles == accept_edge + 2) else begin
          $display("First result after %0d cycles instead of 2", cycles - accept_edge);
          errors++;
        end
      end
      if (out_valid_o && out_ready_i) compare_response();
    end
  end

  // -------------------------------------------------------------------------
  // Stimulus
  // -------------------------------------------------------------------------
  initial begin
    int idx;
    seed        = 71613;
    arst_n_i    = 1'b0;
    in_valid_i  = 1'b0;
    in_req_i    = '0;
    out_ready_i = 1'b0;
    for (int op = 0; op < 4; op++) begin
      integer_case(fma_op_e'(2'(op)), 1'b0);
      integer_case(fma_op_e'(2'(op)), 1'b1);
    end
    for (int i = 0; i < 5; i++) special_case(i);
    for (int m = 0; m < 5; m++) rounding_case(roundmode_e'(3'(m)));
    for (int m = 0; m < 4; m++) overflow_case(roundmode_e'(3'(m)));
    directed_count = stim_q.size();
    // Random mix of the directed behaviors
    for (int i = 0; i < 40; i++) begin
      case ($unsigned($random(seed)) % 4)
        0: integer_case(fma_op_e'(2'($unsigned($random(seed)) % 4)), 1'($random(seed)));
        1: special_case(int'($unsigned($random(seed)) % 5));
        2: rounding_case(roundmode_e'(3'($unsigned($random(seed)) % 5)));
        default: overflow_case(roundmode_e'(3'($unsigned($random(seed)) % 4)));
      endcase
    end
    timeout_limit = stim_q.size() * 20 + 200;
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    arst_n_i = 1'b1;
    // Idle pipe after reset
    repeat (3) @(negedge clk_i);
    idx = 0;
    while (idx < stim_q.size()) begin
      @(negedge clk_i);
      in_valid_i   = 1'b1;
      in_req_i     = stim_q[idx];
      random_ready = (idx >= directed_count);
      #1;
      if (in_ready_o) begin
        if (idx == 0) accept_edge = cycles + 1;
        any_accepted = 1'b1;
        idx++;
      end
    end
    @(negedge clk_i);
    in_valid_i = 1'b0;
    wait (received_count == stim_q.size());
    // Extra responses would show up here
    random_ready = 1'b0;
    repeat (5) @(negedge clk_i);
    $display("Cases %0d, responses %0d, errors %0d", stim_q.size(), received_count, errors);
    if (errors == 0 && expect_q.size() == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== testbench/fma_properties.sv ====
// Handshake properties for fma_top; the input check holds only for a well-behaved source
`default_nettype none

module fma_properties import fma_pkg::*; (
  input logic     clk_i,
  input logic     arst_n_i,
  input logic     in_valid_i,
  input fma_req_t in_req_i,
  input logic     in_ready_o,
  input logic     out_valid_o,
  input fma_rsp_t out_rsp_o,
  input logic     out_ready_i
);

  timeunit 1ns;
  timeprecision 1ps;

  // -------------------------------------------------------------------------
  // Stall stability
  // -------------------------------------------------------------------------
  // Stalled response stays put
  out_stable_a : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_rsp_o))
    else $error("Output response changed while stalled");

  // Stalled request stays put
  in_stable_a : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    in_valid_i && !in_ready_o |=> in_valid_i && $stable(in_req_i))
    else $error("Input request changed while stalled");

  // -------------------------------------------------------------------------
  // Reset and ready path
  // -------------------------------------------------------------------------
  reset_idle_a : assert property (@(posedge clk_i) !arst_n_i |-> !out_valid_o)
    else $error("Output valid during reset");

  // Ready passes straight back through every stage
  ready_path_a : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    out_ready_i |-> in_ready_o)
    else $error("Input not ready while output is ready");

endmodule

bind fma_top fma_properties u_properties (
  .clk_i(clk_i), .arst_n_i(arst_n_i), .in_valid_i(in_valid_i), .in_req_i(in_req_i),
  .in_ready_o(in_ready_o), .out_valid_o(out_valid_o), .out_rsp_o(out_rsp_o),
  .out_ready_i(out_ready_i)
);

`default_nettype wire

// ==== source/fma_top.sv ====
// Two-cycle latency FMA with three stages and combinational back-pressure
`default_nettype none

module fma_top import fma_pkg::*; (
  input  logic     clk_i,
  input  logic     arst_n_i,
  input  logic     in_valid_i,
  input  fma_req_t in_req_i,
  output logic     in_ready_o,
  output logic     out_valid_o,
  output fma_rsp_t out_rsp_o,
  input  logic     out_ready_i
);

  fma_req_t req_q;
  logic     req_valid;
  logic     mid_ready;
  fp32_t    op_a, op_b, op_c;
  fp_info_t info_a, info_b, info_c;
  logic     special;
  fp_word_t special_result;
  status_t  special_status;
  fma_mid_t mid_d, mid_q;
  logic     mid_valid;
  logic     out_ready;
  logic [PRECISION_BITS:0] norm_mantissa;
  exp_t     norm_exponent;
  logic     norm_sticky;
  fma_rsp_t rsp_d;

  // -------------------------------------------------------------------------
  // Input side
  // -------------------------------------------------------------------------
  fma_pipe_reg #(.payload_t(fma_req_t)) u_req_reg (
    .clk_i, .arst_n_i,
    .valid_i(in_valid_i), .data_i(in_req_i), .ready_o(in_ready_o),
    .valid_o(req_valid), .data_o(req_q), .ready_i(mid_ready)
  );

  fma_operand_prep u_prep (
    .req_i(req_q),
    .op_a_o(op_a), .op_b_o(op_b), .op_c_o(op_c),
    .info_a_o(info_a), .info_b_o(info_b), .info_c_o(info_c),
    .special_o(special), .special_result_o(special_result),
    .special_status_o(special_status)
  );

  // -------------------------------------------------------------------------
  // Processing
  // -------------------------------------------------------------------------
  fma_mantissa_add u_madd (
    .op_a_i(op_a), .op_b_i(op_b), .op_c_i(op_c),
    .info_a_i(info_a), .info_b_i(info_b), .info_c_i(info_c),
    .special_i(special), .special_result_i(special_result),
    .special_status_i(special_status),
    .rnd_mode_i(req_q.rnd_mode), .tag_i(req_q.tag), .mid_o(mid_d)
  );

  fma_pipe_reg #(.payload_t(fma_mid_t)) u_mid_reg (
    .clk_i, .arst_n_i,
    .valid_i(req_valid), .data_i(mid_d), .ready_o(mid_ready),
    .valid_o(mid_valid), .data_o(mid_q), .ready_i(out_ready)
  );

  fma_normalize u_norm (
    .mid_i(mid_q), .mantissa_o(norm_mantissa),
    .exponent_o(norm_exponent), .sticky_o(norm_sticky)
  );

  // -------------------------------------------------------------------------
  // Output side
  // -------------------------------------------------------------------------
  fma_round_select u_round (
    .mid_i(mid_q), .mantissa_i(norm_mantissa), .exponent_i(norm_exponent),
    .sticky_i(norm_sticky), .rsp_o(rsp_d)
  );

  fma_pipe_reg #(.payload_t(fma_rsp_t)) u_out_reg (
    .clk_i, .arst_n_i,
    .valid_i(mid_valid), .data_i(rsp_d), .ready_o(out_ready),
    .valid_o(out_valid_o), .data_o(out_rsp_o), .ready_i(out_ready_i)
  );

endmodule

`default_nettype wire

// ==== source/fma_round_select.sv ====
// Combinational rounding with UF checked after rounding as RISC-V requires
`default_nettype none

module fma_round_select import fma_pkg::*; (
  input  fma_mid_t                mid_i,
  input  logic [PRECISION_BITS:0] mantissa_i,
  input  exp_t                    exponent_i,
  input  logic                    sticky_i,
  output fma_rsp_t                rsp_o
);

  logic                         of_before;
  logic                         of_after;
  logic                         uf_after;
  logic [EXP_BITS-1:0]          pre_exponent;
  logic [MAN_BITS-1:0]          pre_mantissa;
  logic [EXP_BITS+MAN_BITS-1:0] pre_abs;
  logic [EXP_BITS+MAN_BITS-1:0] rounded_abs;
  logic [1:0]                   round_sticky;
  logic                         round_up;
  logic                         exact_zero;
  logic                         rounded_sign;
  status_t                      regular_status;

  // Overflow before rounding saturates to max finite
  assign of_before    = exponent_i >= exp_t'(2**EXP_BITS - 1);
  assign pre_exponent = of_before ? EXP_BITS'(2**EXP_BITS - 2) : exponent_i[EXP_BITS-1:0];
  assign pre_mantissa = of_before ? '1 : mantissa_i[MAN_BITS:1];
  assign pre_abs      = {pre_exponent, pre_mantissa};
  // Both bits set so the mode decides inf or max finite
  assign round_sticky = of_before ? 2'b11 : {mantissa_i[0], sticky_i};

  // -------------------------------------------------------------------------
  // Rounding
  // -------------------------------------------------------------------------
  always_comb begin : round_decision
    case (mid_i.rnd_mode)
      // Ties go to the even value
      RNE:     round_up = round_sticky[1] & (round_sticky[0] | pre_abs[0]);
      RTZ:     round_up = 1'b0;
      RDN:     round_up = (|round_sticky) & mid_i.final_sign;
      RUP:     round_up = (|round_sticky) & ~mid_i.final_sign;
      // Ties away from zero
      RMM:     round_up = round_sticky[1];
      default: round_up = 1'b0;
    endcase
  end

  // Mantissa carry rolls into the exponent
  assign rounded_abs  = pre_abs + (EXP_BITS+MAN_BITS)'(round_up);
  assign exact_zero   = (pre_abs == '0) && (round_sticky == 2'b00);
  // Exact cancellation is -0 only when rounding down
  assign rounded_sign = (exact_zero && mid_i.eff_sub) ? (mid_i.rnd_mode == RDN)
                                                      : mid_i.final_sign;

  assign uf_after = ~|rounded_abs[EXP_BITS+MAN_BITS-1:MAN_BITS];
  assign of_after = &rounded_abs[EXP_BITS+MAN_BITS-1:MAN_BITS];

  // -------------------------------------------------------------------------
  // Flags and result selection
  // -------------------------------------------------------------------------
  assign regular_status.NV = 1'b0;
  assign regular_status.OF = of_before | of_after;
  assign regular_status.NX = (|round_sticky) | of_before | of_after;
  // Tiny and inexact
  assign regular_status.UF = uf_after & regular_status.NX;

  assign rsp_o.result = mid_i.special ? mid_i.special_result : {rounded_sign, rounded_abs};
  assign rsp_o.status = mid_i.special ? mid_i.special_status : regular_status;
  assign rsp_o.tag    = mid_i.tag;

endmodule

`default_nettype wire

// ==== source/fma_normalize.sv ====
// Combinational normalization; exponent 0 on output marks a subnormal result
`default_nettype none

module fma_normalize import fma_pkg::*; (
  input  fma_mid_t                mid_i,
  output logic [PRECISION_BITS:0] mantissa_o,
  output exp_t                    exponent_o,
  output logic                    sticky_o
);

  logic [LOWER_SUM_WIDTH-1:0] sum_lower;
  logic [LZC_WIDTH-1:0]       lz_count;
  logic                       lz_empty;
  exp_t                       lz_count_sgn;
  shamt_t                     norm_shamt;
  exp_t                       norm_exponent;
  logic [SUM_WIDTH:0]         sum_shifted;
  logic [LOWER_SUM_WIDTH-1:0] sum_sticky_bits;

  assign sum_lower = mid_i.sum[LOWER_SUM_WIDTH-1:0];

  // First one from the top wins
  always_comb begin : lzc
    lz_count = '0;
    lz_empty = 1'b1;
    for (int i = 0; i < LOWER_SUM_WIDTH; i++) begin
      if (lz_empty && sum_lower[LOWER_SUM_WIDTH-1-i]) begin
        lz_count = LZC_WIDTH'(i);
        lz_empty = 1'b0;
      end
    end
  end

  assign lz_count_sgn = exp_t'(lz_count);

  // -------------------------------------------------------------------------
  // Large shift
  // -------------------------------------------------------------------------
  always_comb begin : norm_shift
    // Product anchored or heavy cancellation
    if ((mid_i.exp_diff <= 0) || (mid_i.eff_sub && (mid_i.exp_diff <= 2))) begin
      if ((mid_i.exp_prod - lz_count_sgn + 1 >= 0) && !lz_empty) begin
        norm_shamt    = shamt_t'(PRECISION_BITS + 2 + lz_count_sgn);
        norm_exponent = exp_t'(mid_i.exp_prod - lz_count_sgn + 1);
      end else begin
        // Stop at the minimum exponent
        norm_shamt    = shamt_t'(PRECISION_BITS + 2 + mid_i.exp_prod);
        norm_exponent = '0;
      end
    end else begin
      // Addend anchored so undo the alignment
      norm_shamt    = mid_i.addend_shamt;
      norm_exponent = mid_i.tent_exp;
    end
  end

  assign sum_shifted = {1'b0, mid_i.sum} << norm_shamt;

  // -------------------------------------------------------------------------
  // One-bit correction
  // -------------------------------------------------------------------------
  always_comb begin : small_norm
    {mantissa_o, sum_sticky_bits} = sum_shifted[SUM_WIDTH-1:0];
    exponent_o                    = norm_exponent;
    // Carry out so move right
    if (sum_shifted[SUM_WIDTH]) begin
      {mantissa_o, sum_sticky_bits} = sum_shifted[SUM_WIDTH:1];
      exponent_o                    = exp_t'(norm_exponent + 1);
    end else if (!sum_shifted[SUM_WIDTH-1] && (norm_exponent > 1)) begin
      {mantissa_o, sum_sticky_bits} = {sum_shifted[SUM_WIDTH-2:0], 1'b0};
      exponent_o                    = exp_t'(norm_exponent - 1);
    end else if (!sum_shifted[SUM_WIDTH-1]) begin
      // Still no leading one
      exponent_o = '0;
    end
  end

  assign sticky_o = (|sum_sticky_bits) | mid_i.sticky;

endmodule

`default_nettype wire

// ==== source/fma_mantissa_add.sv ====
// Combinational product, addend alignment and wide add; exponents stay biased
`default_nettype none

module fma_mantissa_add import fma_pkg::*; (
  input  fp32_t      op_a_i,
  input  fp32_t      op_b_i,
  input  fp32_t      op_c_i,
  input  fp_info_t   info_a_i,
  input  fp_info_t   info_b_i,
  input  fp_info_t   info_c_i,
  input  logic       special_i,
  input  fp_word_t   special_result_i,
  input  status_t    special_status_i,
  input  roundmode_e rnd_mode_i,
  input  tag_t       tag_i,
  output fma_mid_t   mid_o
);

  exp_t exp_a, exp_b, exp_c;
  exp_t exp_addend, exp_prod, exp_diff;
  shamt_t addend_shamt;
  logic eff_sub;
  logic tent_sign;

  logic [PRECISION_BITS-1:0]           man_a, man_b, man_c;
  logic [2*PRECISION_BITS-1:0]         product;
  sum_t                                product_shifted;
  logic [SUM_WIDTH+PRECISION_BITS-1:0] addend_wide;
  sum_t                                addend_aligned;
  sum_t                                addend_shifted;
  logic                                sticky;
  logic                                carry_in;
  logic [SUM_WIDTH:0]                  sum_raw;
  logic                                sum_carry;

  // -------------------------------------------------------------------------
  // Exponents
  // -------------------------------------------------------------------------
  assign exp_a = exp_t'({1'b0, op_a_i.exponent});
  assign exp_b = exp_t'({1'b0, op_b_i.exponent});
  assign exp_c = exp_t'({1'b0, op_c_i.exponent});

  // Subnormals and zero sit at biased exponent 1
  assign exp_addend = exp_c + exp_t'(!info_c_i.is_normal);
  // Zero product goes to the smallest exponent
  assign exp_prod   = (info_a_i.is_zero || info_b_i.is_zero) ? exp_t'(2 - BIAS)
                    : exp_a + exp_t'(info_a_i.is_subnormal)
                      + exp_b + exp_t'(info_b_i.is_subnormal) - exp_t'(BIAS);
  assign exp_diff   = exp_addend - exp_prod;

  always_comb begin : addend_shift_amount
    // Addend only reaches the sticky bit
    if (exp_diff <= -2 * PRECISION_BITS - 1) begin
      addend_shamt = shamt_t'(3 * PRECISION_BITS + 4);
    end else if (exp_diff <= PRECISION_BITS + 2) begin
      addend_shamt = shamt_t'(PRECISION_BITS + 3 - exp_diff);
    end else begin
      // Addend anchored, product only sticky
      addend_shamt = '0;
    end
  end

  // -------------------------------------------------------------------------
  // Product and aligned addend
  // -------------------------------------------------------------------------
  assign man_a   = {info_a_i.is_normal, op_a_i.mantissa};
  assign man_b   = {info_b_i.is_normal, op_b_i.mantissa};
  assign man_c   = {info_c_i.is_normal, op_c_i.mantissa};
  assign product = man_a * man_b;

  // Layout is p+2 zeros, 2p product bits, round and sticky
  assign product_shifted = {{(PRECISION_BITS+2){1'b0}}, product, 2'b00};

  // Low p bits fall off and fold into sticky
  assign addend_wide    = {man_c, {SUM_WIDTH{1'b0}}} >> addend_shamt;
  assign addend_aligned = addend_wide[SUM_WIDTH+PRECISION_BITS-1:PRECISION_BITS];
  assign sticky         = |addend_wide[PRECISION_BITS-1:0];

  // Signs differ so subtract by two's complement
  assign eff_sub        = op_a_i.sign ^ op_b_i.sign ^ op_c_i.sign;
  assign tent_sign      = op_a_i.sign ^ op_b_i.sign;
  assign addend_shifted = eff_sub ? ~addend_aligned : addend_aligned;
  assign carry_in       = eff_sub & ~sticky;

  // -------------------------------------------------------------------------
  // Adder and sign fix
  // -------------------------------------------------------------------------
  assign sum_raw   = {1'b0, product_shifted} + {1'b0, addend_shifted}
                   + (SUM_WIDTH+1)'(carry_in);
  // No carry in a subtraction means the addend was larger
  assign sum_carry = sum_raw[SUM_WIDTH];

  always_comb begin : pack_mid
    mid_o.sum            = (eff_sub && !sum_carry) ? -sum_raw[SUM_WIDTH-1:0]
                                                   : sum_raw[SUM_WIDTH-1:0];
    mid_o.eff_sub        = eff_sub;
    mid_o.exp_prod       = exp_prod;
    mid_o.exp_diff       = exp_diff;
    mid_o.tent_exp       = (exp_diff > 0) ? exp_addend : exp_prod;
    mid_o.addend_shamt   = addend_shamt;
    mid_o.sticky         = sticky;
    mid_o.final_sign     = eff_sub ? (sum_carry == tent_sign) : tent_sign;
    mid_o.rnd_mode       = rnd_mode_i;
    mid_o.special        = special_i;
    mid_o.special_result = special_result_i;
    mid_o.special_status = special_status_i;
    mid_o.tag            = tag_i;
  end

endmodule

`default_nettype wire

// ==== source/fma_operand_prep.sv ====
// Combinational operand setup for binary32 with RISC-V special-case priority
`default_nettype none

module fma_operand_prep import fma_pkg::*; (
  input  fma_req_t req_i,
  output fp32_t    op_a_o,
  output fp32_t    op_b_o,
  output fp32_t    op_c_o,
  output fp_info_t info_a_o,
  output fp_info_t info_b_o,
  output fp_info_t info_c_o,
  output logic     special_o,
  output fp_word_t special_result_o,
  output status_t  special_status_o
);

  // Class bits straight from the exponent and mantissa fields
  function automatic fp_info_t classify(input fp32_t op);
    fp_info_t info;
    logic     exp_ones;
    logic     exp_zero;
    logic     man_zero;
    exp_ones           = &op.exponent;
    exp_zero           = ~|op.exponent;
    man_zero           = ~|op.mantissa;
    info.is_normal     = !exp_ones && !exp_zero;
    info.is_subnormal  = exp_zero && !man_zero;
    info.is_zero       = exp_zero && man_zero;
    info.is_inf        = exp_ones && man_zero;
    info.is_nan        = exp_ones && !man_zero;
    // Quiet bit is the mantissa MSB
    info.is_signalling = info.is_nan && !op.mantissa[MAN_BITS-1];
    return info;
  endfunction

  logic any_inf;
  logic any_nan;
  logic any_snan;
  logic eff_sub;
  logic prod_inf;

  // -------------------------------------------------------------------------
  // Operation adjustments
  // -------------------------------------------------------------------------
  always_comb begin : op_select
    op_a_o   = fp32_t'(req_i.a);
    op_b_o   = fp32_t'(req_i.b);
    op_c_o   = fp32_t'(req_i.c);
    info_a_o = classify(op_a_o);
    info_b_o = classify(op_b_o);
    info_c_o = classify(op_c_o);
    // op_mod flips the addend for every operation
    op_c_o.sign = op_c_o.sign ^ req_i.op_mod;
    unique case (req_i.op)
      FMADD: begin
        op_a_o.sign = op_a_o.sign;
      end
      // Negated product
      FNMSUB: begin
        op_a_o.sign = ~op_a_o.sign;
      end
      // Multiplicand becomes +1.0
      ADD: begin
        op_a_o   = '{sign: 1'b0, exponent: EXP_BITS'(BIAS), mantissa: '0};
        info_a_o = '{is_normal: 1'b1, default: 1'b0};
      end
      // Addend becomes -0.0 so that an exact zero keeps the product sign
      MUL: begin
        op_c_o   = '{sign: 1'b1, exponent: '0, mantissa: '0};
        info_c_o = '{is_zero: 1'b1, default: 1'b0};
      end
    endcase
  end

  assign any_inf  = info_a_o.is_inf | info_b_o.is_inf | info_c_o.is_inf;
  assign any_nan  = info_a_o.is_nan | info_b_o.is_nan | info_c_o.is_nan;
  assign any_snan = info_a_o.is_signalling | info_b_o.is_signalling | info_c_o.is_signalling;
  assign eff_sub  = op_a_o.sign ^ op_b_o.sign ^ op_c_o.sign;
  assign prod_inf = info_a_o.is_inf | info_b_o.is_inf;

  // -------------------------------------------------------------------------
  // Special cases in priority order
  // -------------------------------------------------------------------------
  always_comb begin : special_cases
    special_o        = 1'b0;
    special_result_o = CANONICAL_NAN;
    special_status_o = '0;
    // inf times zero is invalid even with a quiet NaN addend
    if ((info_a_o.is_inf && info_b_o.is_zero) || (info_a_o.is_zero && info_b_o.is_inf)) begin
      special_o           = 1'b1;
      special_status_o.NV = 1'b1;
    end else if (any_nan) begin
      special_o           = 1'b1;
      special_status_o.NV = any_snan;
    end else if (any_inf) begin
      special_o = 1'b1;
      // Opposite infinities cancel
      if (prod_inf && info_c_o.is_inf && eff_sub) begin
        special_status_o.NV = 1'b1;
      end else if (prod_inf) begin
        special_result_o = {op_a_o.sign ^ op_b_o.sign, {EXP_BITS{1'b1}}, {MAN_BITS{1'b0}}};
      end else begin
        special_result_o = {op_c_o.sign, {EXP_BITS{1'b1}}, {MAN_BITS{1'b0}}};
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/fma_pipe_reg.sv ====
// One valid/ready stage with a zero payload after reset and no flush
`default_nettype none

module fma_pipe_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     arst_n_i,
  input  logic     valid_i,
  input  payload_t data_i,
  output logic     ready_o,
  output logic     valid_o,
  output payload_t data_o,
  input  logic     ready_i
);

  logic     valid_q;
  payload_t data_q;
  logic     load;

  // Accept when downstream takes our item or we hold a bubble
  assign ready_o = ready_i | ~valid_q;
  assign load    = valid_i & ready_o;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= 1'b0;
    end else if (ready_o) begin
      valid_q <= valid_i;
    end
  end

  // Payload only moves with a real item
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      data_q <= '0;
    end else if (load) begin
      data_q <= data_i;
    end
  end

  assign valid_o = valid_q;
  assign data_o  = data_q;

endmodule

`default_nettype wire

// ==== source/fma_pkg.sv ====
// Binary32 only with RISC-V NaN rules, four flags and no divide-by-zero flag
`default_nettype none

package fma_pkg;

  // -------------------------------------------------------------------------
  // Format and datapath widths
  // -------------------------------------------------------------------------
  localparam int EXP_BITS        = 8;
  localparam int MAN_BITS        = 23;
  localparam int BIAS            = 127;
  // Mantissa with the implicit bit
  localparam int PRECISION_BITS  = MAN_BITS + 1;
  // Addend, product and round/sticky positions side by side
  localparam int SUM_WIDTH       = 3 * PRECISION_BITS + 4;
  // Lower window searched for leading zeros
  localparam int LOWER_SUM_WIDTH = 2 * PRECISION_BITS + 3;
  localparam int LZC_WIDTH       = $clog2(LOWER_SUM_WIDTH);
  // Holds every meaningful biased exponent plus a sign
  localparam int EXP_WIDTH       = (EXP_BITS + 2 > LZC_WIDTH) ? EXP_BITS + 2 : LZC_WIDTH;
  // Largest shift is 3p+4
  localparam int SHIFT_WIDTH     = $clog2(3 * PRECISION_BITS + 3);
  localparam int TAG_BITS        = 4;

  // -------------------------------------------------------------------------
  // Plain vector types
  // -------------------------------------------------------------------------
  typedef logic [1+EXP_BITS+MAN_BITS-1:0] fp_word_t;
  typedef logic signed [EXP_WIDTH-1:0]    exp_t;
  typedef logic [SHIFT_WIDTH-1:0]         shamt_t;
  typedef logic [SUM_WIDTH-1:0]           sum_t;
  typedef logic [TAG_BITS-1:0]            tag_t;

  // Default quiet NaN for RISC-V
  localparam fp_word_t CANONICAL_NAN = 32'h7FC0_0000;

  typedef enum logic [1:0] {FMADD, FNMSUB, ADD, MUL} fma_op_e;
  typedef enum logic [2:0] {RNE, RTZ, RDN, RUP, RMM} roundmode_e;

  // -------------------------------------------------------------------------
  // Structs
  // -------------------------------------------------------------------------
  typedef struct packed {
    logic                sign;
    logic [EXP_BITS-1:0] exponent;
    logic [MAN_BITS-1:0] mantissa;
  } fp32_t;

  typedef struct packed {
    logic is_normal;
    logic is_subnormal;
    logic is_zero;
    logic is_inf;
    logic is_nan;
    logic is_signalling;
  } fp_info_t;

  typedef struct packed {
    logic NV;
    logic OF;
    logic UF;
    logic NX;
  } status_t;

  typedef struct packed {
    fp_word_t   a;
    fp_word_t   b;
    fp_word_t   c;
    fma_op_e    op;
    logic       op_mod;
    roundmode_e rnd_mode;
    tag_t       tag;
  } fma_req_t;

  // Everything normalization and rounding need after the adder
  typedef struct packed {
    sum_t       sum;
    logic       eff_sub;
    exp_t       exp_prod;
    exp_t       exp_diff;
    exp_t       tent_exp;
    shamt_t     addend_shamt;
    logic       sticky;
    logic       final_sign;
    roundmode_e rnd_mode;
    logic       special;
    fp_word_t   special_result;
    status_t    special_status;
    tag_t       tag;
  } fma_mid_t;

  typedef struct packed {
    fp_word_t result;
    status_t  status;
    tag_t     tag;
  } fma_rsp_t;

endpackage

`default_nettype wire
